//--- Bender.yml
package:
  name: cpu6502_core

sources:
  - cpu6502_pkg.sv
  - program_rom.sv
  - fetch_decode.sv
  - op_queue.sv
  - execute_unit.sv
  - cpu_core.sv
  - target: test
    files:
      - tb_checker.sv
      - tb_cpu.sv

//--- cpu6502_pkg.sv
/*
  Shared types and constants for the small 6502-style core.
  Only ORA/AND/EOR/ADC/LDA/CMP/SBC (immediate and zero page), STA zero page,
  LDX/LDY immediate, the transfers, INx/DEx, CLC, SEC, NOP and BRK exist.
  Every other opcode decodes as illegal. No decimal mode, no I or D flag.
*/
package cpu6502_pkg;

  typedef logic [7:0] byte_t;
  typedef logic [7:0] addr_t;

  // Program memory and zero page are both one page
  localparam int MEM_BYTES = 256;

  localparam int    QUEUE_DEPTH = 4;
  localparam int    QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
  localparam addr_t RESET_PC    = 8'h00;

  // Status register bit positions
  localparam int FLAG_N = 7;
  localparam int FLAG_V = 6;
  localparam int FLAG_B = 4;
  localparam int FLAG_Z = 1;
  localparam int FLAG_C = 0;

  // Group one ALU opcodes, aaa_bbb_01
  localparam byte_t OPC_ORA_IMM = 8'h09;
  localparam byte_t OPC_ORA_ZP  = 8'h05;
  localparam byte_t OPC_AND_IMM = 8'h29;
  localparam byte_t OPC_AND_ZP  = 8'h25;
  localparam byte_t OPC_EOR_IMM = 8'h49;
  localparam byte_t OPC_EOR_ZP  = 8'h45;
  localparam byte_t OPC_ADC_IMM = 8'h69;
  localparam byte_t OPC_ADC_ZP  = 8'h65;
  localparam byte_t OPC_STA_ZP  = 8'h85;
  localparam byte_t OPC_LDA_IMM = 8'hA9;
  localparam byte_t OPC_LDA_ZP  = 8'hA5;
  localparam byte_t OPC_CMP_IMM = 8'hC9;
  localparam byte_t OPC_CMP_ZP  = 8'hC5;
  localparam byte_t OPC_SBC_IMM = 8'hE9;
  localparam byte_t OPC_SBC_ZP  = 8'hE5;

  // Index loads
  localparam byte_t OPC_LDX_IMM = 8'hA2;
  localparam byte_t OPC_LDY_IMM = 8'hA0;

  // Single byte opcodes
  localparam byte_t OPC_TAX = 8'hAA;
  localparam byte_t OPC_TAY = 8'hA8;
  localparam byte_t OPC_TXA = 8'h8A;
  localparam byte_t OPC_TYA = 8'h98;
  localparam byte_t OPC_INX = 8'hE8;
  localparam byte_t OPC_INY = 8'hC8;
  localparam byte_t OPC_DEX = 8'hCA;
  localparam byte_t OPC_DEY = 8'h88;
  localparam byte_t OPC_CLC = 8'h18;
  localparam byte_t OPC_SEC = 8'h38;
  localparam byte_t OPC_NOP = 8'hEA;
  localparam byte_t OPC_BRK = 8'h00;

  typedef enum logic [5:0] {
    OP_ORA, OP_AND, OP_EOR, OP_ADC, OP_STA, OP_LDA, OP_CMP, OP_SBC,
    OP_LDX, OP_LDY, OP_TAX, OP_TAY, OP_TXA, OP_TYA,
    OP_INX, OP_INY, OP_DEX, OP_DEY, OP_CLC, OP_SEC, OP_NOP,
    OP_BRK, OP_ILLEGAL
  } op_kind_t;

  typedef enum logic [2:0] {
    FETCH_OP, WAIT_OP, FETCH_ARG, WAIT_ARG, PUSH, STOPPED
  } fetch_state_t;

  typedef enum logic [1:0] {
    RUN, ZP_READ, HALTED, FAULT
  } exec_state_t;

endpackage

//--- cpu_core.sv
/*
  Top of the core: program memory, fetch/decode, operation queue, execute.
  Load the program with reset held low, then release reset to run from
  address 0. halted or fault rising marks the end of a run.
*/
`timescale 1ns/10ps

module cpu_core (
  input  logic               raw_clk,
  input  logic               button_reset,
  input  logic               prog_we,
  input  cpu6502_pkg::addr_t prog_addr,
  input  cpu6502_pkg::byte_t prog_data,
  output cpu6502_pkg::byte_t reg_a,
  output cpu6502_pkg::byte_t reg_x,
  output cpu6502_pkg::byte_t reg_y,
  output cpu6502_pkg::byte_t status,
  output logic               halted,
  output logic               fault
);

  cpu6502_pkg::addr_t    rom_addr;
  cpu6502_pkg::byte_t    rom_data;

  // Fetch to queue
  logic                  push;
  cpu6502_pkg::op_kind_t op_kind;
  cpu6502_pkg::byte_t    operand;
  logic                  zp_mode;
  logic                  queue_full;

  // Queue to execute
  logic                  pop;
  cpu6502_pkg::op_kind_t head_kind;
  cpu6502_pkg::byte_t    head_operand;
  logic                  head_zp;
  logic                  queue_empty;

  program_rom rom (
    .raw_clk   (raw_clk),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .rom_addr  (rom_addr),
    .rom_data  (rom_data)
  );

  fetch_decode fetch (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .rom_data     (rom_data),
    .queue_full   (queue_full),
    .rom_addr     (rom_addr),
    .push         (push),
    .op_kind      (op_kind),
    .operand      (operand),
    .zp_mode      (zp_mode)
  );

  op_queue queue (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .push         (push),
    .in_kind      (op_kind),
    .in_operand   (operand),
    .in_zp        (zp_mode),
    .pop          (pop),
    .head_kind    (head_kind),
    .head_operand (head_operand),
    .head_zp      (head_zp),
    .queue_full   (queue_full),
    .queue_empty  (queue_empty)
  );

  execute_unit exec (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .head_kind    (head_kind),
    .head_operand (head_operand),
    .head_zp      (head_zp),
    .queue_empty  (queue_empty),
    .pop          (pop),
    .reg_a        (reg_a),
    .reg_x        (reg_x),
    .reg_y        (reg_y),
    .status       (status),
    .halted       (halted),
    .fault        (fault)
  );

endmodule

//--- execute_unit.sv
/*
  Register file, status flags, zero-page RAM and ALU.
  Register and immediate operations retire in one cycle, zero-page reads
  in two (RUN then ZP_READ). BRK sets B and halts, an illegal opcode
  faults with registers untouched. Zero-page RAM is not cleared by reset.
*/
`timescale 1ns/10ps

module execute_unit (
  input  logic                  raw_clk,
  input  logic                  button_reset,
  input  cpu6502_pkg::op_kind_t head_kind,
  input  cpu6502_pkg::byte_t    head_operand,
  input  logic                  head_zp,
  input  logic                  queue_empty,
  output logic                  pop,
  output cpu6502_pkg::byte_t    reg_a,
  output cpu6502_pkg::byte_t    reg_x,
  output cpu6502_pkg::byte_t    reg_y,
  output cpu6502_pkg::byte_t    status,
  output logic                  halted,
  output logic                  fault
);

  cpu6502_pkg::exec_state_t state;
  cpu6502_pkg::byte_t       zp_ram [0:cpu6502_pkg::MEM_BYTES-1];
  cpu6502_pkg::byte_t       ram_q;
  cpu6502_pkg::byte_t       m;
  cpu6502_pkg::byte_t       m_alu;
  cpu6502_pkg::byte_t       a_nxt;
  cpu6502_pkg::byte_t       x_nxt;
  cpu6502_pkg::byte_t       y_nxt;
  cpu6502_pkg::byte_t       status_nxt;
  cpu6502_pkg::byte_t       nz_src;
  logic [8:0]               sum;
  logic                     carry_in;
  logic                     zp_read;

  // STA is the only zero-page op that needs no read
  assign zp_read = head_zp && (head_kind != cpu6502_pkg::OP_STA);

  assign pop = !queue_empty &&
               (((state == cpu6502_pkg::RUN) && !zp_read) ||
                (state == cpu6502_pkg::ZP_READ));

  assign halted = (state == cpu6502_pkg::HALTED);
  assign fault  = (state == cpu6502_pkg::FAULT);

  // Operand comes from RAM in the second cycle of a zero-page read
  assign m = (state == cpu6502_pkg::ZP_READ) ? ram_q : head_operand;

  // Shared adder, subtract as A + ~M + C, compare with C forced
  always_comb
  begin
    m_alu    = (head_kind inside {cpu6502_pkg::OP_SBC, cpu6502_pkg::OP_CMP}) ? ~m : m;
    carry_in = (head_kind == cpu6502_pkg::OP_CMP) ? 1'b1 : status[cpu6502_pkg::FLAG_C];
    sum      = {1'b0, reg_a} + {1'b0, m_alu} + {8'd0, carry_in};
  end

  always_comb
  begin
    a_nxt      = reg_a;
    x_nxt      = reg_x;
    y_nxt      = reg_y;
    status_nxt = status;
    case (head_kind)
      cpu6502_pkg::OP_ORA: a_nxt = reg_a | m;
      cpu6502_pkg::OP_AND: a_nxt = reg_a & m;
      cpu6502_pkg::OP_EOR: a_nxt = reg_a ^ m;
      cpu6502_pkg::OP_LDA: a_nxt = m;
      cpu6502_pkg::OP_ADC, cpu6502_pkg::OP_SBC:
      begin
        a_nxt = sum[7:0];
        status_nxt[cpu6502_pkg::FLAG_C] = sum[8];
        // Signed overflow, operands agree in sign and result does not
        status_nxt[cpu6502_pkg::FLAG_V] = (reg_a[7] == m_alu[7]) && (sum[7] != reg_a[7]);
      end
      cpu6502_pkg::OP_CMP: status_nxt[cpu6502_pkg::FLAG_C] = sum[8];
      cpu6502_pkg::OP_LDX: x_nxt = m;
      cpu6502_pkg::OP_LDY: y_nxt = m;
      cpu6502_pkg::OP_TAX: x_nxt = reg_a;
      cpu6502_pkg::OP_TAY: y_nxt = reg_a;
      cpu6502_pkg::OP_TXA: a_nxt = reg_x;
      cpu6502_pkg::OP_TYA: a_nxt = reg_y;
      cpu6502_pkg::OP_INX: x_nxt = reg_x + 8'd1;
      cpu6502_pkg::OP_INY: y_nxt = reg_y + 8'd1;
      cpu6502_pkg::OP_DEX: x_nxt = reg_x - 8'd1;
      cpu6502_pkg::OP_DEY: y_nxt = reg_y - 8'd1;
      cpu6502_pkg::OP_CLC: status_nxt[cpu6502_pkg::FLAG_C] = 1'b0;
      cpu6502_pkg::OP_SEC: status_nxt[cpu6502_pkg::FLAG_C] = 1'b1;
      cpu6502_pkg::OP_BRK: status_nxt[cpu6502_pkg::FLAG_B] = 1'b1;
      default: a_nxt = reg_a;
    endcase

    // N and Z follow whichever register the op wrote
    nz_src = a_nxt;
    case (head_kind)
      cpu6502_pkg::OP_LDX, cpu6502_pkg::OP_TAX,
      cpu6502_pkg::OP_INX, cpu6502_pkg::OP_DEX: nz_src = x_nxt;
      cpu6502_pkg::OP_LDY, cpu6502_pkg::OP_TAY,
      cpu6502_pkg::OP_INY, cpu6502_pkg::OP_DEY: nz_src = y_nxt;
      cpu6502_pkg::OP_CMP: nz_src = sum[7:0];
      default: nz_src = a_nxt;
    endcase
    if (!(head_kind inside {cpu6502_pkg::OP_STA, cpu6502_pkg::OP_CLC, cpu6502_pkg::OP_SEC,
                            cpu6502_pkg::OP_NOP, cpu6502_pkg::OP_BRK,
                            cpu6502_pkg::OP_ILLEGAL}))
    begin
      status_nxt[cpu6502_pkg::FLAG_N] = nz_src[7];
      status_nxt[cpu6502_pkg::FLAG_Z] = (nz_src == 8'd0);
    end
  end

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      state  <= cpu6502_pkg::RUN;
      reg_a  <= '0;
      reg_x  <= '0;
      reg_y  <= '0;
      status <= '0;
    end
    else
    begin
      if (pop)
      begin
        reg_a  <= a_nxt;
        reg_x  <= x_nxt;
        reg_y  <= y_nxt;
        status <= status_nxt;
      end
      case (state)
        cpu6502_pkg::RUN:
        begin
          if (!queue_empty)
          begin
            if (head_kind == cpu6502_pkg::OP_BRK)
              state <= cpu6502_pkg::HALTED;
            else if (head_kind == cpu6502_pkg::OP_ILLEGAL)
              state <= cpu6502_pkg::FAULT;
            else if (zp_read)
              state <= cpu6502_pkg::ZP_READ;
          end
        end
        cpu6502_pkg::ZP_READ:
          state <= cpu6502_pkg::RUN;
        // HALTED and FAULT hold until reset
        default:
          state <= state;
      endcase
    end
  end

  // Zero page, STA writes as it retires, reads are registered
  always_ff @(posedge raw_clk)
  begin
    if (pop && (head_kind == cpu6502_pkg::OP_STA))
    begin
      zp_ram[head_operand] <= reg_a;
    end
    ram_q <= zp_ram[head_operand];
  end

endmodule

//--- fetch_decode.sv
/*
  Program counter, byte fetch and opcode decode.
  Each byte costs an address cycle and a data cycle; one more cycle pushes.
  The entry is held in PUSH while the queue is full.
  After BRK or an illegal opcode the unit stops until reset.
*/
`timescale 1ns/10ps

module fetch_decode (
  input  logic                  raw_clk,
  input  logic                  button_reset,
  input  cpu6502_pkg::byte_t    rom_data,
  input  logic                  queue_full,
  output cpu6502_pkg::addr_t    rom_addr,
  output logic                  push,
  output cpu6502_pkg::op_kind_t op_kind,
  output cpu6502_pkg::byte_t    operand,
  output logic                  zp_mode
);

  cpu6502_pkg::fetch_state_t state;
  cpu6502_pkg::addr_t        pc;
  cpu6502_pkg::op_kind_t     dec_kind;
  logic                      dec_arg;
  logic                      dec_zp;
  logic                      stop_after;

  assign rom_addr = pc;
  assign push     = (state == cpu6502_pkg::PUSH) && !queue_full;

  assign stop_after = (op_kind == cpu6502_pkg::OP_BRK) ||
                      (op_kind == cpu6502_pkg::OP_ILLEGAL);

  // Opcode byte to operation
  always_comb
  begin
    case (rom_data)
      cpu6502_pkg::OPC_ORA_IMM, cpu6502_pkg::OPC_ORA_ZP: dec_kind = cpu6502_pkg::OP_ORA;
      cpu6502_pkg::OPC_AND_IMM, cpu6502_pkg::OPC_AND_ZP: dec_kind = cpu6502_pkg::OP_AND;
      cpu6502_pkg::OPC_EOR_IMM, cpu6502_pkg::OPC_EOR_ZP: dec_kind = cpu6502_pkg::OP_EOR;
      cpu6502_pkg::OPC_ADC_IMM, cpu6502_pkg::OPC_ADC_ZP: dec_kind = cpu6502_pkg::OP_ADC;
      cpu6502_pkg::OPC_LDA_IMM, cpu6502_pkg::OPC_LDA_ZP: dec_kind = cpu6502_pkg::OP_LDA;
      cpu6502_pkg::OPC_CMP_IMM, cpu6502_pkg::OPC_CMP_ZP: dec_kind = cpu6502_pkg::OP_CMP;
      cpu6502_pkg::OPC_SBC_IMM, cpu6502_pkg::OPC_SBC_ZP: dec_kind = cpu6502_pkg::OP_SBC;
      cpu6502_pkg::OPC_STA_ZP:  dec_kind = cpu6502_pkg::OP_STA;
      cpu6502_pkg::OPC_LDX_IMM: dec_kind = cpu6502_pkg::OP_LDX;
      cpu6502_pkg::OPC_LDY_IMM: dec_kind = cpu6502_pkg::OP_LDY;
      cpu6502_pkg::OPC_TAX:     dec_kind = cpu6502_pkg::OP_TAX;
      cpu6502_pkg::OPC_TAY:     dec_kind = cpu6502_pkg::OP_TAY;
      cpu6502_pkg::OPC_TXA:     dec_kind = cpu6502_pkg::OP_TXA;
      cpu6502_pkg::OPC_TYA:     dec_kind = cpu6502_pkg::OP_TYA;
      cpu6502_pkg::OPC_INX:     dec_kind = cpu6502_pkg::OP_INX;
      cpu6502_pkg::OPC_INY:     dec_kind = cpu6502_pkg::OP_INY;
      cpu6502_pkg::OPC_DEX:     dec_kind = cpu6502_pkg::OP_DEX;
      cpu6502_pkg::OPC_DEY:     dec_kind = cpu6502_pkg::OP_DEY;
      cpu6502_pkg::OPC_CLC:     dec_kind = cpu6502_pkg::OP_CLC;
      cpu6502_pkg::OPC_SEC:     dec_kind = cpu6502_pkg::OP_SEC;
      cpu6502_pkg::OPC_NOP:     dec_kind = cpu6502_pkg::OP_NOP;
      cpu6502_pkg::OPC_BRK:     dec_kind = cpu6502_pkg::OP_BRK;
      // Includes every xxxxxx11 opcode
      default:                  dec_kind = cpu6502_pkg::OP_ILLEGAL;
    endcase
  end

  // Two byte instructions; bbb = 001 marks zero page among them
  assign dec_arg = dec_kind inside {cpu6502_pkg::OP_ORA, cpu6502_pkg::OP_AND,
                                    cpu6502_pkg::OP_EOR, cpu6502_pkg::OP_ADC,
                                    cpu6502_pkg::OP_STA, cpu6502_pkg::OP_LDA,
                                    cpu6502_pkg::OP_CMP, cpu6502_pkg::OP_SBC,
                                    cpu6502_pkg::OP_LDX, cpu6502_pkg::OP_LDY};
  assign dec_zp  = dec_arg && (rom_data[4:2] == 3'b001);

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      state <= cpu6502_pkg::FETCH_OP;
      pc    <= cpu6502_pkg::RESET_PC;
    end
    else
    begin
      case (state)
        cpu6502_pkg::FETCH_OP:
          state <= cpu6502_pkg::WAIT_OP;
        cpu6502_pkg::WAIT_OP:
        begin
          pc    <= pc + 8'd1;
          state <= dec_arg ? cpu6502_pkg::FETCH_ARG : cpu6502_pkg::PUSH;
        end
        cpu6502_pkg::FETCH_ARG:
          state <= cpu6502_pkg::WAIT_ARG;
        cpu6502_pkg::WAIT_ARG:
        begin
          pc    <= pc + 8'd1;
          state <= cpu6502_pkg::PUSH;
        end
        cpu6502_pkg::PUSH:
        begin
          // Stall here on back-pressure
          if (!queue_full)
          begin
            state <= stop_after ? cpu6502_pkg::STOPPED : cpu6502_pkg::FETCH_OP;
          end
        end
        default:
          state <= cpu6502_pkg::STOPPED;
      endcase
    end
  end

  // Queue entry being built
  always_ff @(posedge raw_clk)
  begin
    if (state == cpu6502_pkg::WAIT_OP)
    begin
      op_kind <= dec_kind;
      zp_mode <= dec_zp;
      operand <= '0;
    end
    else if (state == cpu6502_pkg::WAIT_ARG)
    begin
      operand <= rom_data;
    end
  end

endmodule

//--- op_queue.sv
/*
  Circular FIFO of decoded operations.
  push and pop are one-cycle strobes and may coincide.
  queue_full and queue_empty are registered; a push while full
  or a pop while empty is ignored.
*/
`timescale 1ns/10ps

module op_queue (
  input  logic                  raw_clk,
  input  logic                  button_reset,
  input  logic                  push,
  input  cpu6502_pkg::op_kind_t in_kind,
  input  cpu6502_pkg::byte_t    in_operand,
  input  logic                  in_zp,
  input  logic                  pop,
  output cpu6502_pkg::op_kind_t head_kind,
  output cpu6502_pkg::byte_t    head_operand,
  output logic                  head_zp,
  output logic                  queue_full,
  output logic                  queue_empty
);

  cpu6502_pkg::op_kind_t kind_mem    [0:cpu6502_pkg::QUEUE_DEPTH-1];
  cpu6502_pkg::byte_t    operand_mem [0:cpu6502_pkg::QUEUE_DEPTH-1];
  logic                  zp_mem      [0:cpu6502_pkg::QUEUE_DEPTH-1];

  logic [cpu6502_pkg::QUEUE_PTR_W-1:0] wr_ptr;
  logic [cpu6502_pkg::QUEUE_PTR_W-1:0] rd_ptr;
  logic [cpu6502_pkg::QUEUE_PTR_W:0]   count;
  logic [cpu6502_pkg::QUEUE_PTR_W:0]   count_nxt;
  logic                                do_push;
  logic                                do_pop;

  assign do_push = push && !queue_full;
  assign do_pop  = pop && !queue_empty;

  assign head_kind    = kind_mem[rd_ptr];
  assign head_operand = operand_mem[rd_ptr];
  assign head_zp      = zp_mem[rd_ptr];

  always_comb
  begin
    case ({do_push, do_pop})
      2'b10:   count_nxt = count + 1'b1;
      2'b01:   count_nxt = count - 1'b1;
      default: count_nxt = count;
    endcase
  end

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
      queue_full  <= 1'b0;
      queue_empty <= 1'b1;
    end
    else
    begin
      if (do_push)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count       <= count_nxt;
      queue_full  <= (count_nxt == cpu6502_pkg::QUEUE_DEPTH);
      queue_empty <= (count_nxt == 0);
    end
  end

  // Entry storage
  always_ff @(posedge raw_clk)
  begin
    if (do_push)
    begin
      kind_mem[wr_ptr]    <= in_kind;
      operand_mem[wr_ptr] <= in_operand;
      zp_mem[wr_ptr]      <= in_zp;
    end
  end

endmodule

//--- program_rom.sv
/*
  Program memory, one page of bytes.
  Load port writes work in reset and out of it; contents survive reset.
  Read data appears one clock after rom_addr.
*/
`timescale 1ns/10ps

module program_rom (
  input  logic               raw_clk,
  input  logic               prog_we,
  input  cpu6502_pkg::addr_t prog_addr,
  input  cpu6502_pkg::byte_t prog_data,
  input  cpu6502_pkg::addr_t rom_addr,
  output cpu6502_pkg::byte_t rom_data
);

  cpu6502_pkg::byte_t mem [0:cpu6502_pkg::MEM_BYTES-1];

  // Load port
  always_ff @(posedge raw_clk)
  begin
    if (prog_we)
    begin
      mem[prog_addr] <= prog_data;
    end
  end

  // Fetch side, registered read
  always_ff @(posedge raw_clk)
  begin
    rom_data <= mem[rom_addr];
  end

endmodule

//--- tb.f
cpu6502_pkg.sv
program_rom.sv
fetch_decode.sv
op_queue.sv
execute_unit.sv
cpu_core.sv
tb_checker.sv
tb_cpu.sv

//--- tb_checker.sv
/*
  Result checker for the cpu_core testbench.
  Armed once per test, it waits for halted or fault, then compares the
  registers with the expected values and pulses done for one cycle.
  DUT outputs are sampled on the rising edge, before that edge's updates.
*/
`timescale 1ns/10ps

module tb_checker (
  input  logic               raw_clk,
  input  logic               arm,
  input  logic [127:0]       test_name,
  input  cpu6502_pkg::byte_t exp_a,
  input  cpu6502_pkg::byte_t exp_x,
  input  cpu6502_pkg::byte_t exp_y,
  input  cpu6502_pkg::byte_t exp_status,
  input  logic               exp_fault,
  input  cpu6502_pkg::byte_t reg_a,
  input  cpu6502_pkg::byte_t reg_x,
  input  cpu6502_pkg::byte_t reg_y,
  input  cpu6502_pkg::byte_t status,
  input  logic               halted,
  input  logic               fault,
  output logic               done,
  output int                 pass_count,
  output int                 fail_count
);

  logic active;

  // Returns 1 on a mismatch, X counts as wrong
  function automatic int compare_reg(input logic [127:0] name, input string reg_name,
                                     input cpu6502_pkg::byte_t expected,
                                     input cpu6502_pkg::byte_t actual);
    if (actual !== expected)
    begin
      $display("FAILED %0s: %0s expected %02h, actual %02h",
               name, reg_name, expected, actual);
      return 1;
    end
    return 0;
  endfunction

  initial
  begin
    active     = 1'b0;
    done       = 1'b0;
    pass_count = 0;
    fail_count = 0;
  end

  always @(posedge raw_clk)
  begin : compare
    int errs;
    errs = 0;
    done <= 1'b0;
    if (arm)
    begin
      active <= 1'b1;
    end
    else if (active && (halted || fault))
    begin
      active <= 1'b0;
      done   <= 1'b1;
      if (exp_fault && !fault)
      begin
        $display("%0s: the core halted, but an illegal opcode fault was expected",
                 test_name);
        errs++;
      end
      else if (!exp_fault && fault)
      begin
        $display("%0s: the core faulted, but a halt on BRK was expected", test_name);
        errs++;
      end
      else if (halted && fault)
      begin
        $display("%0s: halted and fault are both high at the end", test_name);
        errs++;
      end
      errs += compare_reg(test_name, "A", exp_a, reg_a);
      errs += compare_reg(test_name, "X", exp_x, reg_x);
      errs += compare_reg(test_name, "Y", exp_y, reg_y);
      errs += compare_reg(test_name, "status", exp_status, status);
      if (errs == 0)
      begin
        $display("passed %0s", test_name);
        pass_count <= pass_count + 1;
      end
      else
      begin
        fail_count <= fail_count + 1;
      end
    end
  end

endmodule

//--- tb_cpu.sv
/*
  Testbench for cpu_core. Each table row is a program of up to 16 bytes
  plus the A, X, Y, status and fault expected when it stops.
  Programs are written with reset held low and run from address 0.
  Bytes beyond a short program keep the previous row's contents.
*/
`timescale 1ns/10ps

module tb_cpu;

  localparam int NUM_ROWS    = 15;
  localparam int CYCLE_LIMIT = 100 * NUM_ROWS;

  logic               raw_clk;
  logic               button_reset;
  logic               prog_we;
  cpu6502_pkg::addr_t prog_addr;
  cpu6502_pkg::byte_t prog_data;
  cpu6502_pkg::byte_t reg_a;
  cpu6502_pkg::byte_t reg_x;
  cpu6502_pkg::byte_t reg_y;
  cpu6502_pkg::byte_t status;
  logic               halted;
  logic               fault;

  // Expected values handed to the checker
  logic               arm;
  logic [127:0]       cur_name;
  cpu6502_pkg::byte_t exp_a;
  cpu6502_pkg::byte_t exp_x;
  cpu6502_pkg::byte_t exp_y;
  cpu6502_pkg::byte_t exp_status;
  logic               exp_fault;
  logic               done;
  int                 pass_count;
  int                 fail_count;

  // Test table
  logic [127:0]       row_name   [NUM_ROWS];
  logic [127:0]       row_prog   [NUM_ROWS];
  int                 row_len    [NUM_ROWS];
  cpu6502_pkg::byte_t row_a      [NUM_ROWS];
  cpu6502_pkg::byte_t row_x      [NUM_ROWS];
  cpu6502_pkg::byte_t row_y      [NUM_ROWS];
  cpu6502_pkg::byte_t row_status [NUM_ROWS];
  logic               row_fault  [NUM_ROWS];
  int                 rows;
  int                 cur_row;
  int                 cycles;

  cpu_core uut (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .prog_we      (prog_we),
    .prog_addr    (prog_addr),
    .prog_data    (prog_data),
    .reg_a        (reg_a),
    .reg_x        (reg_x),
    .reg_y        (reg_y),
    .status       (status),
    .halted       (halted),
    .fault        (fault)
  );

  tb_checker chk (
    .raw_clk    (raw_clk),
    .arm        (arm),
    .test_name  (cur_name),
    .exp_a      (exp_a),
    .exp_x      (exp_x),
    .exp_y      (exp_y),
    .exp_status (exp_status),
    .exp_fault  (exp_fault),
    .reg_a      (reg_a),
    .reg_x      (reg_x),
    .reg_y      (reg_y),
    .status     (status),
    .halted     (halted),
    .fault      (fault),
    .done       (done),
    .pass_count (pass_count),
    .fail_count (fail_count)
  );

  always #20 raw_clk = ~raw_clk;

  // Program bytes are right aligned, first byte in the highest used lane
  task automatic add_row(input logic [127:0] name, input cpu6502_pkg::byte_t a,
                         input cpu6502_pkg::byte_t x, input cpu6502_pkg::byte_t y,
                         input cpu6502_pkg::byte_t st, input logic flt,
                         input int len, input logic [127:0] bytes);
    row_name[rows]   = name;
    row_a[rows]      = a;
    row_x[rows]      = x;
    row_y[rows]      = y;
    row_status[rows] = st;
    row_fault[rows]  = flt;
    row_len[rows]    = len;
    row_prog[rows]   = bytes;
    rows++;
  endtask

  // Status is N V - B - - Z C, so B alone is 8'h10
  task automatic build_table();
    rows = 0;
    // FF + 01 carries out to zero
    add_row("adc_carry", 8'h00, 8'h00, 8'h00, 8'h13, 1'b0, 5,
            {cpu6502_pkg::OPC_LDA_IMM, 8'hFF, cpu6502_pkg::OPC_ADC_IMM, 8'h01,
             cpu6502_pkg::OPC_BRK});
    // 50 + 50 overflows into the sign bit
    add_row("adc_overflow", 8'hA0, 8'h00, 8'h00, 8'hD0, 1'b0, 7,
            {cpu6502_pkg::OPC_SEC, cpu6502_pkg::OPC_CLC, cpu6502_pkg::OPC_LDA_IMM, 8'h50,
             cpu6502_pkg::OPC_ADC_IMM, 8'h50, cpu6502_pkg::OPC_BRK});
    add_row("logic_zero", 8'h00, 8'h00, 8'h00, 8'h12, 1'b0, 9,
            {cpu6502_pkg::OPC_LDA_IMM, 8'hF0, cpu6502_pkg::OPC_AND_IMM, 8'h3C,
             cpu6502_pkg::OPC_ORA_IMM, 8'hC3, cpu6502_pkg::OPC_EOR_IMM, 8'hF3,
             cpu6502_pkg::OPC_BRK});
    add_row("logic_neg", 8'h80, 8'h00, 8'h00, 8'h90, 1'b0, 7,
            {cpu6502_pkg::OPC_LDA_IMM, 8'h0F, cpu6502_pkg::OPC_ORA_IMM, 8'h80,
             cpu6502_pkg::OPC_EOR_IMM, 8'h0F, cpu6502_pkg::OPC_BRK});
    // 50 - 20 leaves C set, 10 - 20 borrows
    add_row("sbc_no_borrow", 8'h30, 8'h00, 8'h00, 8'h11, 1'b0, 6,
            {cpu6502_pkg::OPC_SEC, cpu6502_pkg::OPC_LDA_IMM, 8'h50,
             cpu6502_pkg::OPC_SBC_IMM, 8'h20, cpu6502_pkg::OPC_BRK});
    add_row("sbc_borrow", 8'hF0, 8'h00, 8'h00, 8'h90, 1'b0, 6,
            {cpu6502_pkg::OPC_SEC, cpu6502_pkg::OPC_LDA_IMM, 8'h10,
             cpu6502_pkg::OPC_SBC_IMM, 8'h20, cpu6502_pkg::OPC_BRK});
    add_row("cmp_below", 8'h10, 8'h00, 8'h00, 8'h90, 1'b0, 5,
            {cpu6502_pkg::OPC_LDA_IMM, 8'h10, cpu6502_pkg::OPC_CMP_IMM, 8'h20,
             cpu6502_pkg::OPC_BRK});
    add_row("cmp_equal", 8'h42, 8'h00, 8'h00, 8'h13, 1'b0, 5,
            {cpu6502_pkg::OPC_LDA_IMM, 8'h42, cpu6502_pkg::OPC_CMP_IMM, 8'h42,
             cpu6502_pkg::OPC_BRK});
    add_row("cmp_above", 8'h80, 8'h00, 8'h00, 8'h11, 1'b0, 5,
            {cpu6502_pkg::OPC_LDA_IMM, 8'h80, cpu6502_pkg::OPC_CMP_IMM, 8'h01,
             cpu6502_pkg::OPC_BRK});
    // Store 21 and 35, read back 21 into X, then 35 + 21
    add_row("zero_page", 8'h56, 8'h21, 8'h00, 8'h10, 1'b0, 16,
            {cpu6502_pkg::OPC_LDA_IMM, 8'h21, cpu6502_pkg::OPC_STA_ZP, 8'h10,
             cpu6502_pkg::OPC_LDA_IMM, 8'h35, cpu6502_pkg::OPC_STA_ZP, 8'h11,
             cpu6502_pkg::OPC_LDA_ZP, 8'h10, cpu6502_pkg::OPC_TAX,
             cpu6502_pkg::OPC_LDA_ZP, 8'h11, cpu6502_pkg::OPC_ADC_ZP, 8'h10,
             cpu6502_pkg::OPC_BRK});
    // Y through A into X, decrement, back through A into Y, then INY
    add_row("transfers", 8'h80, 8'h80, 8'h81, 8'h90, 1'b0, 9,
            {cpu6502_pkg::OPC_LDY_IMM, 8'h81, cpu6502_pkg::OPC_TYA, cpu6502_pkg::OPC_TAX,
             cpu6502_pkg::OPC_DEX, cpu6502_pkg::OPC_TXA, cpu6502_pkg::OPC_TAY,
             cpu6502_pkg::OPC_INY, cpu6502_pkg::OPC_BRK});
    add_row("inx_wrap", 8'h00, 8'h00, 8'h00, 8'h12, 1'b0, 4,
            {cpu6502_pkg::OPC_LDX_IMM, 8'hFF, cpu6502_pkg::OPC_INX, cpu6502_pkg::OPC_BRK});
    // C stays set across the decrement
    add_row("dey_wrap", 8'h00, 8'h00, 8'hFF, 8'h91, 1'b0, 5,
            {cpu6502_pkg::OPC_SEC, cpu6502_pkg::OPC_LDY_IMM, 8'h00,
             cpu6502_pkg::OPC_DEY, cpu6502_pkg::OPC_BRK});
    // Six INX, four INY, two NOP
    add_row("long_run", 8'h00, 8'h06, 8'h04, 8'h10, 1'b0, 13,
            {cpu6502_pkg::OPC_INX, cpu6502_pkg::OPC_INX, cpu6502_pkg::OPC_INY,
             cpu6502_pkg::OPC_NOP, cpu6502_pkg::OPC_INX, cpu6502_pkg::OPC_INY,
             cpu6502_pkg::OPC_INY, cpu6502_pkg::OPC_NOP, cpu6502_pkg::OPC_INX,
             cpu6502_pkg::OPC_INX, cpu6502_pkg::OPC_INY, cpu6502_pkg::OPC_INX,
             cpu6502_pkg::OPC_BRK});
    // 03 has low bits 11
    add_row("illegal_op", 8'h5A, 8'h00, 8'h00, 8'h00, 1'b1, 4,
            {cpu6502_pkg::OPC_LDA_IMM, 8'h5A, 8'h03, cpu6502_pkg::OPC_BRK});
  endtask

  task automatic run_row(input int r);
    cur_row = r;
    @(posedge raw_clk);
    button_reset <= 1'b0;
    repeat (3) @(posedge raw_clk);
    for (int i = 0; i < row_len[r]; i++)
    begin
      prog_we   <= 1'b1;
      prog_addr <= cpu6502_pkg::addr_t'(i);
      prog_data <= row_prog[r][8*(row_len[r]-1-i) +: 8];
      @(posedge raw_clk);
    end
    prog_we      <= 1'b0;
    button_reset <= 1'b1;
    cur_name     <= row_name[r];
    exp_a        <= row_a[r];
    exp_x        <= row_x[r];
    exp_y        <= row_y[r];
    exp_status   <= row_status[r];
    exp_fault    <= row_fault[r];
    arm          <= 1'b1;
    @(posedge raw_clk);
    arm <= 1'b0;
    @(posedge raw_clk);
    while (!done)
    begin
      @(posedge raw_clk);
    end
  endtask

  initial
  begin
    raw_clk      = 1'b0;
    button_reset = 1'b0;
    prog_we      = 1'b0;
    prog_addr    = '0;
    prog_data    = '0;
    arm          = 1'b0;
    cur_name     = '0;
    exp_a        = '0;
    exp_x        = '0;
    exp_y        = '0;
    exp_status   = '0;
    exp_fault    = 1'b0;
    cur_row      = 0;
    cycles       = 0;
    build_table();
    for (int r = 0; r < rows; r++)
    begin
      run_row(r);
    end
    @(posedge raw_clk);
    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

  // Run length guard
  always @(posedge raw_clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("Timeout after %0d cycles: test %0s never halted or faulted",
               cycles, row_name[cur_row]);
      $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
      $display("FAIL: see errors above");
      $finish;
    end
  end

endmodule
